// File: common/credit_sync_pkg.sv
`default_nettype none

`include "credit_sync_settings.svh"

package credit_sync_pkg;

  // a number of credits, wide enough for a full remote buffer
  typedef logic [`CS_CREDIT_W-1:0] credit_t;

  // the payload carried by a data packet
  typedef logic [`CS_DATA_W-1:0] data_t;

  // the packet that goes onto the link
  // cred_only marks a packet whose data field carries nothing
  // credits holds the entries freed locally since the last packet
  typedef struct packed {
    logic    cred_only;
    credit_t credits;
    data_t   data;
  } tx_pkt_t;

  // credits handed back by the remote side
  typedef struct packed {
    logic    valid;
    credit_t amount;
  } credit_ret_t;

  // one output transfer and the number of remote entries it takes
  typedef struct packed {
    logic    fire;
    credit_t cost;
  } tx_fire_t;

endpackage

`default_nettype wire

// File: common/credit_sync_settings.svh
`ifndef CREDIT_SYNC_SETTINGS_SVH
`define CREDIT_SYNC_SETTINGS_SVH

// depth of the remote receive buffer, every entry there is one credit
// the available count starts at this value after reset
`define CS_NUM_CREDITS 16

// a credit count must hold CS_NUM_CREDITS itself, so one bit above log2
`define CS_CREDIT_W 5

// payload width of one data packet
`define CS_DATA_W 32

// owed credits at or above this level are pushed out even without data
// it has to stay above zero or the link sends empty packets forever
`define CS_FORCE_SEND_THRESH 12

// remote buffer entries taken by one credits-only packet
`define CS_CRED_ONLY_COST 1

`endif

// File: compile.f
+incdir+common
common/credit_sync_pkg.sv
credit_sync/tx_mode_ctrl.sv
credit_sync/avail_credit_counter.sv
credit_sync/return_credit_counter.sv
credit_sync/credit_sync_top.sv
tb/credit_sync_assertions.sv
tb/credit_sync_tb.sv

// File: credit_sync/avail_credit_counter.sv
`timescale 1ns/100ps
`default_nettype none

`include "credit_sync_settings.svh"

module avail_credit_counter import credit_sync_pkg::*; (
  input  wire logic        clk_i,
  input  wire logic        reset_i,
  input  wire credit_ret_t cred_ret_i,
  input  wire tx_fire_t    tx_fire_i,
  output credit_t          credits_avail_o
);

  localparam credit_t ResetCredits = credit_t'(`CS_NUM_CREDITS);

  // free entries left in the remote receive buffer
  credit_t avail_q;
  credit_t avail_d;
  credit_t incr;
  credit_t decr;

  ////////////////////////////////////////////////////////////
  // counter update
  ////////////////////////////////////////////////////////////

  // credits coming back from the remote side free up entries there
  assign incr = cred_ret_i.valid ? cred_ret_i.amount : '0;

  // each packet that leaves takes its cost out of the remote buffer
  assign decr = tx_fire_i.fire ? tx_fire_i.cost : '0;

  // both can happen in one cycle, the admission rule keeps this from wrapping
  assign avail_d = avail_q + incr - decr;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // the remote buffer is empty after reset, so every entry is ours
      avail_q <= ResetCredits;
    end else begin
      avail_q <= avail_d;
    end
  end

  // the registered value feeds admission, a return shows up one cycle later
  assign credits_avail_o = avail_q;

endmodule

`default_nettype wire

// File: credit_sync/credit_sync_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "credit_sync_settings.svh"

module credit_sync_top import credit_sync_pkg::*; (
  input  wire logic        clk_i,
  input  wire logic        reset_i,
  // local data source
  input  wire data_t       data_i,
  input  wire logic        send_valid_i,
  output logic             send_ready_o,
  // link toward the remote receiver
  output tx_pkt_t          pkt_o,
  output logic             send_valid_o,
  input  wire logic        send_ready_i,
  // credits handed back by the remote side
  input  wire credit_ret_t cred_ret_i,
  // one pulse per entry freed in the local receive buffer
  input  wire logic        release_i
);

  ////////////////////////////////////////////////////////////
  // internal wiring
  ////////////////////////////////////////////////////////////

  // the transfer event, shared by both counters
  tx_fire_t tx_fire;
  credit_t  credits_avail;
  credit_t  credits_owed;

  // packet type selection, admission and the source/link handshake
  tx_mode_ctrl u_tx_mode_ctrl (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .data_i        (data_i),
    .send_valid_i  (send_valid_i),
    .send_ready_i  (send_ready_i),
    .credits_avail (credits_avail),
    .credits_owed  (credits_owed),
    .send_valid_o  (send_valid_o),
    .send_ready_o  (send_ready_o),
    .pkt_o         (pkt_o),
    .tx_fire_o     (tx_fire)
  );

  // room left in the remote receive buffer
  avail_credit_counter u_avail_credit_counter (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .cred_ret_i      (cred_ret_i),
    .tx_fire_i       (tx_fire),
    .credits_avail_o (credits_avail)
  );

  // credits owed to the remote side, held steady while the link stalls
  return_credit_counter u_return_credit_counter (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .release_i      (release_i),
    .send_valid_i   (send_valid_o),
    .tx_fire_i      (tx_fire),
    .credits_owed_o (credits_owed)
  );

endmodule

`default_nettype wire

// File: credit_sync/return_credit_counter.sv
`timescale 1ns/100ps
`default_nettype none

`include "credit_sync_settings.svh"

module return_credit_counter import credit_sync_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     reset_i,
  input  wire logic     release_i,
  input  wire logic     send_valid_i,
  input  wire tx_fire_t tx_fire_i,
  output credit_t       credits_owed_o
);

  // visible count, this is what the outgoing packet carries
  credit_t owed_q;
  credit_t owed_d;
  // shadow count, collects releases while a packet waits on the link
  credit_t shadow_q;
  credit_t shadow_d;
  // one freed local entry as a credit count
  credit_t rel_inc;
  // output offered but not taken, the visible count has to hold still
  logic    stalled;

  assign rel_inc = credit_t'(release_i);
  assign stalled = send_valid_i & ~tx_fire_i.fire;

  ////////////////////////////////////////////////////////////
  // visible and shadow counts
  ////////////////////////////////////////////////////////////

  always_comb begin
    owed_d   = owed_q;
    shadow_d = shadow_q;
    if (tx_fire_i.fire) begin
      // the visible credits left with the packet, so they are gone here
      // what piled up in the shadow meanwhile becomes the new visible count
      owed_d   = shadow_q + rel_inc;
      shadow_d = '0;
    end else if (stalled) begin
      // the link sees the same credit field until the transfer happens
      shadow_d = shadow_q + rel_inc;
    end else begin
      // nothing on the wire, releases count straight into the visible value
      owed_d = owed_q + rel_inc;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      owed_q   <= '0;
      shadow_q <= '0;
    end else begin
      owed_q   <= owed_d;
      shadow_q <= shadow_d;
    end
  end

  // the shadow never drives the output, it only waits for the next fire
  assign credits_owed_o = owed_q;

endmodule

`default_nettype wire

// File: credit_sync/tx_mode_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "credit_sync_settings.svh"

module tx_mode_ctrl import credit_sync_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     reset_i,
  input  wire data_t    data_i,
  input  wire logic     send_valid_i,
  input  wire logic     send_ready_i,
  input  wire credit_t  credits_avail,
  input  wire credit_t  credits_owed,
  output logic          send_valid_o,
  output logic          send_ready_o,
  output tx_pkt_t       pkt_o,
  output tx_fire_t      tx_fire_o
);

  localparam credit_t DataCost     = credit_t'(1);
  localparam credit_t CredOnlyCost = credit_t'(`CS_CRED_ONLY_COST);
  localparam credit_t ForceThresh  = credit_t'(`CS_FORCE_SEND_THRESH);

  // high while the output carries a credits-only packet instead of source data
  logic    cred_only_q;
  logic    cred_only_d;
  logic    force_send;
  logic    data_permit;
  logic    cred_only_permit;
  logic    cur_permit;
  logic    fire;
  credit_t cur_cost;

  // a packet may take the last remote entries only when credits travel back with it,
  // otherwise both sides could end up waiting on each other with nothing in flight
  function automatic logic permit(input credit_t cost, input credit_t avail,
                                  input credit_t owed);
    return (avail > cost) || ((avail == cost) && (owed != '0));
  endfunction

  ////////////////////////////////////////////////////////////
  // packet admission
  ////////////////////////////////////////////////////////////

  assign data_permit      = permit(DataCost, credits_avail, credits_owed);
  assign cred_only_permit = permit(CredOnlyCost, credits_avail, credits_owed);

  // too many owed credits piled up, they have to leave even without data
  assign force_send = (credits_owed >= ForceThresh);

  // cost and permit of whatever packet type is currently selected
  assign cur_cost   = cred_only_q ? CredOnlyCost : DataCost;
  assign cur_permit = cred_only_q ? cred_only_permit : data_permit;

  // in credits-only mode the output is valid on its own, no source data needed
  assign send_valid_o = cur_permit & (send_valid_i | cred_only_q);
  assign fire         = send_valid_o & send_ready_i;

  // the source only sees a handshake when its own data goes out
  assign send_ready_o = send_ready_i & ~cred_only_q & send_valid_o;

  assign tx_fire_o.fire = fire;
  assign tx_fire_o.cost = cur_cost;

  ////////////////////////////////////////////////////////////
  // outgoing packet
  ////////////////////////////////////////////////////////////

  assign pkt_o.cred_only = cred_only_q;
  assign pkt_o.credits   = credits_owed;
  // the data field is zeroed so a credits-only packet never leaks stale source data
  assign pkt_o.data      = cred_only_q ? '0 : data_i;

  ////////////////////////////////////////////////////////////
  // mode register
  ////////////////////////////////////////////////////////////

  always_comb begin
    cred_only_d = cred_only_q;
    if (fire) begin
      // whatever went out carried the owed credits, so go back to normal data
      cred_only_d = 1'b0;
    end else if (force_send && (!send_valid_i || (!data_permit && cred_only_permit))) begin
      // no data to piggyback on, or data is blocked while a credits-only
      // packet would still fit, so switch over
      cred_only_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cred_only_q <= 1'b0;
    end else begin
      cred_only_q <= cred_only_d;
    end
  end

endmodule

`default_nettype wire

// File: tb/credit_sync_assertions.sv
`timescale 1ns/100ps
`default_nettype none

`include "credit_sync_settings.svh"

module credit_sync_assertions import credit_sync_pkg::*; (
  input wire logic    clk_i,
  input wire logic    reset_i,
  input wire logic    send_valid_o,
  input wire logic    send_ready_o,
  input wire logic    send_ready_i,
  input wire tx_pkt_t pkt_o,
  input wire credit_t credits_avail,
  input wire credit_t credits_owed,
  input wire credit_t shadow_owed
);

  // running total of assertion failures in this run
  int fail_count = 0;

  ////////////////////////////////////////////////////////////
  // credit bounds
  ////////////////////////////////////////////////////////////

  // the remote buffer can never hand back more room than it has
  a_avail_bounded: assert property (@(posedge clk_i) disable iff (reset_i)
    int'(credits_avail) <= `CS_NUM_CREDITS)
    else begin
      $error("available credits exceed the remote buffer depth");
      fail_count++;
    end

  // everything owed together fits in the local buffer
  a_owed_bounded: assert property (@(posedge clk_i) disable iff (reset_i)
    (int'(credits_owed) + int'(shadow_owed)) <= `CS_NUM_CREDITS)
    else begin
      $error("visible plus shadow owed credits exceed the buffer depth");
      fail_count++;
    end

  ////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////

  a_ready_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    send_ready_o |-> send_valid_o)
    else begin
      $error("send_ready_o high without send_valid_o");
      fail_count++;
    end

  // a stalled packet keeps its header until the link takes it
  a_stall_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (send_valid_o && !send_ready_i) |=> ($stable(pkt_o.credits) && $stable(pkt_o.cred_only)))
    else begin
      $error("packet credit field or flag changed during back-pressure");
      fail_count++;
    end

endmodule

bind credit_sync_top credit_sync_assertions u_credit_sync_assertions (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .send_valid_o  (send_valid_o),
  .send_ready_o  (send_ready_o),
  .send_ready_i  (send_ready_i),
  .pkt_o         (pkt_o),
  .credits_avail (credits_avail),
  .credits_owed  (credits_owed),
  .shadow_owed   (u_return_credit_counter.shadow_q)
);

`default_nettype wire

// File: tb/credit_sync_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "credit_sync_settings.svh"

module credit_sync_tb import credit_sync_pkg::*; ();

  localparam int WaitLimit = 64;

  logic        clk_i;
  logic        reset_i;
  data_t       data_i;
  logic        send_valid_i;
  logic        send_ready_o;
  tx_pkt_t     pkt_o;
  logic        send_valid_o;
  logic        send_ready_i;
  credit_ret_t cred_ret_i;
  logic        release_i;

  int checks;
  int errors;
  int timeouts;
  int assert_fails;
  // running model of the remote buffer room updated on each transfer and return
  int exp_avail;

  credit_sync_top dut (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .data_i       (data_i),
    .send_valid_i (send_valid_i),
    .send_ready_o (send_ready_o),
    .pkt_o        (pkt_o),
    .send_valid_o (send_valid_o),
    .send_ready_i (send_ready_i),
    .cred_ret_i   (cred_ret_i),
    .release_i    (release_i)
  );

  // 100 ns period
  always #50 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // compare tasks and helpers
  ////////////////////////////////////////////////////////////

  task automatic check_pkt(input string name, input tx_pkt_t got, input tx_pkt_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_credit(input string name, input credit_t got, input credit_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  function automatic tx_pkt_t make_pkt(input logic flag, input int cred, input data_t d);
    tx_pkt_t p;
    p.cred_only = flag;
    p.credits   = credit_t'(cred);
    p.data      = d;
    return p;
  endfunction

  // inputs change shortly after the rising edge and outputs are read at the falling edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // one release pulse per freed entry with an idle cycle between pulses
  task automatic pulse_releases(input int count);
    repeat (count) begin
      next_cycle();
      release_i = 1'b1;
      next_cycle();
      release_i = 1'b0;
    end
  endtask

  // the source and link are held idle so no transfer slips past unchecked
  task automatic return_credits(input int amount);
    next_cycle();
    send_valid_i      = 1'b0;
    send_ready_i      = 1'b0;
    cred_ret_i.valid  = 1'b1;
    cred_ret_i.amount = credit_t'(amount);
    exp_avail         = exp_avail + amount;
    next_cycle();
    cred_ret_i = '0;
  endtask

  // streams data with the link always ready until send_valid_o drops
  task automatic drain_credits(input int exp_count);
    int    sent;
    int    cycles;
    data_t d;
    sent   = 0;
    cycles = 0;
    next_cycle();
    d            = $urandom;
    data_i       = d;
    send_valid_i = 1'b1;
    send_ready_i = 1'b1;
    @(negedge clk_i);
    while (send_valid_o && cycles < WaitLimit) begin
      check_pkt("pkt_o", pkt_o, make_pkt(1'b0, 0, d));
      check_bit("send_ready_o", send_ready_o, 1'b1);
      sent++;
      exp_avail--;
      next_cycle();
      d      = $urandom;
      data_i = d;
      @(negedge clk_i);
      cycles++;
    end
    if (send_valid_o) begin
      timeouts++;
      $display("timeout: send_valid_o never dropped while credits were drained");
    end
    check_credit("transfer count", credit_t'(sent), credit_t'(exp_count));
    check_credit("credits_avail", dut.credits_avail, credit_t'(exp_avail));
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    data_t d;
    next_cycle();
    d      = $urandom;
    data_i = d;
    @(negedge clk_i);
    check_pkt("pkt_o", pkt_o, make_pkt(1'b0, 0, d));
    check_bit("send_valid_o", send_valid_o, 1'b0);
    check_bit("send_ready_o", send_ready_o, 1'b0);
    // valid follows the source and ready stays low while the link holds back
    next_cycle();
    d            = $urandom;
    data_i       = d;
    send_valid_i = 1'b1;
    @(negedge clk_i);
    check_pkt("pkt_o", pkt_o, make_pkt(1'b0, 0, d));
    check_bit("send_valid_o", send_valid_o, 1'b1);
    check_bit("send_ready_o", send_ready_o, 1'b0);
  endtask

  task automatic test_exhaustion();
    // the last credit is kept back while nothing is owed
    drain_credits(`CS_NUM_CREDITS - 1);
    repeat (4) begin
      next_cycle();
      @(negedge clk_i);
      check_bit("send_valid_o", send_valid_o, 1'b0);
    end
  endtask

  task automatic test_credit_return();
    return_credits(4);
    drain_credits(4);
  endtask

  task automatic test_backpressure();
    data_t d;
    return_credits(12);
    pulse_releases(3);
    @(negedge clk_i);
    check_credit("pkt_o.credits", pkt_o.credits, credit_t'(3));
    // stall the link so new releases land in the shadow count
    next_cycle();
    d            = $urandom;
    data_i       = d;
    send_valid_i = 1'b1;
    send_ready_i = 1'b0;
    pulse_releases(2);
    @(negedge clk_i);
    check_pkt("pkt_o", pkt_o, make_pkt(1'b0, 3, d));
    check_bit("send_valid_o", send_valid_o, 1'b1);
    check_bit("send_ready_o", send_ready_o, 1'b0);
    next_cycle();
    send_ready_i = 1'b1;
    @(negedge clk_i);
    check_pkt("pkt_o", pkt_o, make_pkt(1'b0, 3, d));
    check_bit("send_ready_o", send_ready_o, 1'b1);
    exp_avail--;
    next_cycle();
    send_valid_i = 1'b0;
    send_ready_i = 1'b0;
    @(negedge clk_i);
    check_credit("pkt_o.credits", pkt_o.credits, credit_t'(2));
  endtask

  task automatic test_force_send();
    data_t d;
    int    cycles;
    // one data packet carries the two leftover credits away first
    next_cycle();
    d            = $urandom;
    data_i       = d;
    send_valid_i = 1'b1;
    send_ready_i = 1'b1;
    @(negedge clk_i);
    check_pkt("pkt_o", pkt_o, make_pkt(1'b0, 2, d));
    exp_avail--;
    next_cycle();
    send_valid_i = 1'b0;
    send_ready_i = 1'b0;
    @(negedge clk_i);
    check_credit("pkt_o.credits", pkt_o.credits, credit_t'(0));
    pulse_releases(`CS_FORCE_SEND_THRESH);
    cycles = 0;
    @(negedge clk_i);
    while (!send_valid_o && cycles < WaitLimit) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!send_valid_o) begin
      timeouts++;
      $display("timeout: no credits-only packet was offered after the releases");
    end
    check_pkt("pkt_o", pkt_o, make_pkt(1'b1, `CS_FORCE_SEND_THRESH, '0));
    check_bit("send_ready_o", send_ready_o, 1'b0);
    next_cycle();
    send_ready_i = 1'b1;
    @(negedge clk_i);
    // the source is never acknowledged for a credits-only packet
    check_bit("send_ready_o", send_ready_o, 1'b0);
    exp_avail = exp_avail - `CS_CRED_ONLY_COST;
    next_cycle();
    send_ready_i = 1'b0;
    @(negedge clk_i);
    check_credit("credits_avail", dut.credits_avail, credit_t'(exp_avail));
    check_credit("pkt_o.credits", pkt_o.credits, credit_t'(0));
    check_bit("pkt_o.cred_only", pkt_o.cred_only, 1'b0);
    check_bit("send_valid_o", send_valid_o, 1'b0);
    // back in normal mode data passes through again
    next_cycle();
    d            = $urandom;
    data_i       = d;
    send_valid_i = 1'b1;
    send_ready_i = 1'b1;
    @(negedge clk_i);
    check_pkt("pkt_o", pkt_o, make_pkt(1'b0, 0, d));
    check_bit("send_ready_o", send_ready_o, 1'b1);
    exp_avail--;
    next_cycle();
    send_valid_i = 1'b0;
    send_ready_i = 1'b0;
    @(negedge clk_i);
    check_credit("credits_avail", dut.credits_avail, credit_t'(exp_avail));
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    data_i       = '0;
    send_valid_i = 1'b0;
    send_ready_i = 1'b0;
    cred_ret_i   = '0;
    release_i    = 1'b0;
    checks       = 0;
    errors       = 0;
    timeouts     = 0;
    assert_fails = 0;
    exp_avail    = `CS_NUM_CREDITS;
    void'($urandom(35383));
    repeat (16) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    test_reset_state();
    test_exhaustion();
    test_credit_return();
    test_backpressure();
    test_force_send();
    assert_fails = dut.u_credit_sync_assertions.fail_count;
    $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
             checks, errors, timeouts, assert_fails);
    if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
